// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

  // pixel position inside the frame, counts from 0 at top left
  typedef logic [10:0] coord_t;

  // raw camera word, red in [15:11], green in [10:5], blue in [4:0]
  typedef logic [15:0] rgb565_t;

  // one widened color channel
  typedef logic [7:0] chan_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb888_t;

  // incoming stream word
  typedef struct packed {
    coord_t  hcount;
    coord_t  vcount;
    rgb565_t rgb565;
  } pix_in_t;

  // display stream word
  typedef struct packed {
    coord_t  hcount;
    coord_t  vcount;
    rgb888_t rgb888;
  } pix_out_t;

  // decode -> execute payload
  typedef struct packed {
    coord_t  hcount;
    coord_t  vcount;
    rgb888_t rgb888;
    chan_t   chan; // tracked channel picked by the decoder
  } dec_beat_t;

  // execute -> result payload, same fields plus the threshold result
  typedef struct packed {
    coord_t  hcount;
    coord_t  vcount;
    rgb888_t rgb888;
    chan_t   chan;
    logic    mask; // 1 when chan sits inside the bounds
  } exe_beat_t;

endpackage

`default_nettype wire

// ==== track_pkg.sv ====
`default_nettype none

package track_pkg;

  import video_pkg::*;

  // channel to track, code 3 is not defined and falls back to blue
  typedef enum logic [1:0] {
    SEL_RED   = 2'd0,
    SEL_GREEN = 2'd1,
    SEL_BLUE  = 2'd2
  } chan_sel_e;

  typedef enum logic [1:0] {
    DISP_CAMERA    = 2'd0, // plain camera pixel
    DISP_CHANNEL   = 2'd1, // tracked channel as grayscale
    DISP_MASK      = 2'd2, // binary mask, white or black
    DISP_CROSSHAIR = 2'd3  // camera with lines through the center of mass
  } disp_mode_e;

  typedef struct packed {
    chan_sel_e  chan_sel;
    chan_t      lower;     // inclusive
    chan_t      upper;     // inclusive
    disp_mode_e disp_mode;
  } track_cfg_t;

  typedef logic [16:0] area_t; // masked pixel count, fits 320x180
  typedef logic [27:0] sum_t;  // coordinate sum over one frame

  typedef struct packed {
    coord_t x;
    coord_t y;
    area_t  area;
  } com_t;

  typedef enum logic [1:0] {
    IDLE,   // accumulating, divider free
    DIVIDE, // one quotient bit per clock
    DONE    // result pulse
  } centroid_state_e;

endpackage

`default_nettype wire

// ==== pixel_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_decode import video_pkg::*, track_pkg::*; (
  input  wire       clk_pixel,
  input  wire       recent_reset,
  // incoming camera stream
  input  wire pix_in_t   in_i,
  input  wire       in_valid_i,
  output logic      in_ready_o,
  input  wire chan_sel_e sel_i,
  // toward the execute stage
  output dec_beat_t out_o,
  output logic      out_valid_o,
  input  wire       out_ready_i
);

  rgb888_t wide;  // 565 word widened to 8 bits a channel
  chan_t   chosen;
  logic    take;

  // low bits padded with zeros, no rounding
  always_comb begin
    wide.red   = {in_i.rgb565[15:11], 3'b000};
    wide.green = {in_i.rgb565[10:5], 2'b00};
    wide.blue  = {in_i.rgb565[4:0], 3'b000};
  end

  always_comb begin
    case (sel_i)
      SEL_RED:   chosen = wide.red;
      SEL_GREEN: chosen = wide.green;
      default:   chosen = wide.blue; // blue and the unused code
    endcase
  end

  // register is free when empty or draining this clock
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign take       = in_valid_i && in_ready_o;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i; // bubble when nothing comes in
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge clk_pixel) begin
    if (take) begin
      out_o.hcount <= in_i.hcount;
      out_o.vcount <= in_i.vcount;
      out_o.rgb888 <= wide;
      out_o.chan   <= chosen;
    end
  end

endmodule

`default_nettype wire

// ==== blob_centroid.sv ====
`timescale 1ns/100ps
`default_nettype none

module blob_centroid import video_pkg::*, track_pkg::*; #(
  parameter int HRES = 320,
  parameter int VRES = 180
) (
  input  wire       clk_pixel,
  input  wire       recent_reset,
  input  wire dec_beat_t in_i,
  input  wire       in_valid_i,
  output logic      in_ready_o,
  input  wire chan_t lower_i,
  input  wire chan_t upper_i,
  output exe_beat_t out_o,
  output logic      out_valid_o,
  input  wire       out_ready_i,
  output com_t      com_o,
  output logic      com_valid_o
);

  // mean of a coordinate never exceeds the coordinate range,
  // so the quotient needs only coord_t bits
  localparam int QW = $bits(coord_t);
  localparam coord_t LAST_H = coord_t'(HRES - 1);
  localparam coord_t LAST_V = coord_t'(VRES - 1);

  typedef logic [$clog2(QW)-1:0] cnt_t;

  centroid_state_e state_q;

  logic  mask_in;
  logic  frame_end;
  logic  div_busy;
  logic  take;
  sum_t  sum_x_q, sum_y_q;   // running sums for the current frame
  area_t area_q;
  sum_t  sum_x_nxt, sum_y_nxt;
  area_t area_nxt;

  sum_t  rem_x, rem_y;       // partial remainders
  sum_t  div_d;              // area shifted to the current quotient bit
  coord_t quot_x, quot_y;
  area_t area_hold;          // frozen area of the frame being divided
  cnt_t  bit_cnt;

  assign mask_in   = (in_i.chan >= lower_i) && (in_i.chan <= upper_i);
  assign frame_end = (in_i.hcount == LAST_H) && (in_i.vcount == LAST_V);
  assign div_busy  = (state_q != IDLE);

  // a frame end must wait until the divider can take its sums
  assign in_ready_o = (!out_valid_o || out_ready_i) && !(in_valid_i && frame_end && div_busy);
  assign take       = in_valid_i && in_ready_o;

  // sums including the beat now being taken
  always_comb begin
    sum_x_nxt = sum_x_q;
    sum_y_nxt = sum_y_q;
    area_nxt  = area_q;
    if (mask_in) begin
      sum_x_nxt = sum_x_q + sum_t'(in_i.hcount);
      sum_y_nxt = sum_y_q + sum_t'(in_i.vcount);
      area_nxt  = area_q + area_t'(1);
    end
  end

  // stage register
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      out_valid_o <= 1'b0;
    end else if (!out_valid_o || out_ready_i) begin
      out_valid_o <= take;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (take) begin
      out_o.hcount <= in_i.hcount;
      out_o.vcount <= in_i.vcount;
      out_o.rgb888 <= in_i.rgb888;
      out_o.chan   <= in_i.chan;
      out_o.mask   <= mask_in;
    end
  end

  // accumulators, restart after the last pixel of a frame
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      area_q  <= '0;
    end else if (take) begin
      if (frame_end) begin
        sum_x_q <= '0;
        sum_y_q <= '0;
        area_q  <= '0;
      end else begin
        sum_x_q <= sum_x_nxt;
        sum_y_q <= sum_y_nxt;
        area_q  <= area_nxt;
      end
    end
  end

  // divider control
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // empty frame keeps the previous result, no pulse
          if (take && frame_end && (area_nxt != '0)) state_q <= DIVIDE;
        end
        DIVIDE: begin
          if (bit_cnt == '0) state_q <= DONE;
        end
        default: state_q <= IDLE; // DONE lasts one clock
      endcase
    end
  end

  // restoring divide, msb of the quotient first
  always_ff @(posedge clk_pixel) begin
    if (state_q == IDLE) begin
      rem_x     <= sum_x_nxt;
      rem_y     <= sum_y_nxt;
      div_d     <= sum_t'(area_nxt) << (QW - 1);
      area_hold <= area_nxt;
      bit_cnt   <= cnt_t'(QW - 1);
    end else if (state_q == DIVIDE) begin
      if (rem_x >= div_d) begin
        rem_x  <= rem_x - div_d;
        quot_x <= {quot_x[QW-2:0], 1'b1};
      end else begin
        quot_x <= {quot_x[QW-2:0], 1'b0};
      end
      if (rem_y >= div_d) begin
        rem_y  <= rem_y - div_d;
        quot_y <= {quot_y[QW-2:0], 1'b1};
      end else begin
        quot_y <= {quot_y[QW-2:0], 1'b0};
      end
      div_d   <= div_d >> 1;
      bit_cnt <= bit_cnt - cnt_t'(1);
    end
  end

  assign com_o.x      = quot_x; // truncated means
  assign com_o.y      = quot_y;
  assign com_o.area   = area_hold;
  assign com_valid_o  = (state_q == DONE);

endmodule

`default_nettype wire

// ==== overlay_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module overlay_result import video_pkg::*, track_pkg::*; (
  input  wire       clk_pixel,
  input  wire       recent_reset,
  input  wire exe_beat_t in_i,
  input  wire       in_valid_i,
  output logic      in_ready_o,
  input  wire disp_mode_e mode_i,
  input  wire com_t com_i,
  input  wire       com_valid_i,
  output pix_out_t  out_o,
  output logic      out_valid_o,
  input  wire       out_ready_i
);

  localparam rgb888_t WHITE = '1;
  localparam rgb888_t BLACK = '0;

  coord_t  com_x_q, com_y_q; // last reported center of mass
  rgb888_t shown;
  logic    on_cross;
  logic    take;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      com_x_q <= '0;  // crosshair sits on row 0 and column 0 until a report
      com_y_q <= '0;
    end else if (com_valid_i) begin
      com_x_q <= com_i.x;
      com_y_q <= com_i.y;
    end
  end

  assign on_cross = (in_i.hcount == com_x_q) || (in_i.vcount == com_y_q);

  // display mux
  always_comb begin
    case (mode_i)
      DISP_CHANNEL: begin
        shown.red   = in_i.chan;
        shown.green = in_i.chan;
        shown.blue  = in_i.chan;
      end
      DISP_MASK:      shown = in_i.mask ? WHITE : BLACK;
      DISP_CROSSHAIR: shown = on_cross ? WHITE : in_i.rgb888;
      default:        shown = in_i.rgb888; // camera
    endcase
  end

  assign in_ready_o = !out_valid_o || out_ready_i;
  assign take       = in_valid_i && in_ready_o;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (take) begin
      out_o.hcount <= in_i.hcount;
      out_o.vcount <= in_i.vcount;
      out_o.rgb888 <= shown;
    end
  end

endmodule

`default_nettype wire

// ==== color_tracker_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module color_tracker_top import video_pkg::*, track_pkg::*; #(
  parameter int HRES = 320, // frame width in pixels
  parameter int VRES = 180  // frame height in lines
) (
  input  wire        clk_pixel,
  input  wire        recent_reset,
  input  wire pix_in_t    pix_i,
  input  wire        pix_valid_i,
  output logic       pix_ready_o,
  input  wire track_cfg_t cfg_i,   // held steady between frames
  output pix_out_t   pix_o,
  output logic       pix_valid_o,
  input  wire        out_ready_i,
  output com_t       com_o,
  output logic       com_valid_o
);

  dec_beat_t dec_beat;  // decode -> execute
  logic      dec_valid;
  logic      dec_ready;
  exe_beat_t exe_beat;  // execute -> result
  logic      exe_valid;
  logic      exe_ready;

  pixel_decode decode0 (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .in_i         (pix_i),
    .in_valid_i   (pix_valid_i),
    .in_ready_o   (pix_ready_o),
    .sel_i        (cfg_i.chan_sel),
    .out_o        (dec_beat),
    .out_valid_o  (dec_valid),
    .out_ready_i  (dec_ready)
  );

  blob_centroid #(.HRES(HRES), .VRES(VRES)) centroid0 (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .in_i         (dec_beat),
    .in_valid_i   (dec_valid),
    .in_ready_o   (dec_ready),
    .lower_i      (cfg_i.lower),
    .upper_i      (cfg_i.upper),
    .out_o        (exe_beat),
    .out_valid_o  (exe_valid),
    .out_ready_i  (exe_ready),
    .com_o        (com_o),
    .com_valid_o  (com_valid_o)   // also feeds the overlay latch
  );

  overlay_result result0 (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .in_i         (exe_beat),
    .in_valid_i   (exe_valid),
    .in_ready_o   (exe_ready),
    .mode_i       (cfg_i.disp_mode),
    .com_i        (com_o),
    .com_valid_i  (com_valid_o),
    .out_o        (pix_o),
    .out_valid_o  (pix_valid_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_color_tracker_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_color_tracker_properties import video_pkg::*, track_pkg::*; (
  input wire           clk_pixel,
  input wire           recent_reset,
  input wire pix_in_t  pix_i,
  input wire           pix_valid_i,
  input wire           pix_ready_o,
  input wire pix_out_t pix_o,
  input wire           pix_valid_o,
  input wire           out_ready_i,
  input wire com_t     com_o,
  input wire           com_valid_o,
  input wire           dec_ready_i  // execute stage ready toward decode
);

  int assert_fails = 0; // summed into the closing report

  // valids drop in the clock that follows a reset clock
  reset_quiet: assert property (@(posedge clk_pixel)
    recent_reset |=> (!pix_valid_o && !com_valid_o))
    else begin
      assert_fails++;
      $error("pix_valid_o or com_valid_o high right after reset");
    end

  // a stalled output beat keeps its valid and its payload
  out_hold: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    (pix_valid_o && !out_ready_i) |=> (pix_valid_o && $stable(pix_o)))
    else begin
      assert_fails++;
      $error("pix_o or pix_valid_o changed while out_ready_i was low");
    end

  // three register stages, beat shows up three clocks after acceptance
  in_latency: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    (pix_valid_i && pix_ready_o) ##1 (out_ready_i && dec_ready_i) ##1 out_ready_i
    |=> (pix_valid_o && pix_o.hcount == $past(pix_i.hcount, 3)
         && pix_o.vcount == $past(pix_i.vcount, 3)))
    else begin
      assert_fails++;
      $error("accepted beat did not reach pix_o three clocks later");
    end

  // result strobe is one clock wide and never reports an empty frame
  com_pulse: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    com_valid_o |-> (com_o.area != '0) ##1 !com_valid_o)
    else begin
      assert_fails++;
      $error("com_valid_o stayed high for more than one clock or reported zero area");
    end

endmodule

bind color_tracker_top tb_color_tracker_properties props0 (
  .clk_pixel    (clk_pixel),
  .recent_reset (recent_reset),
  .pix_i        (pix_i),
  .pix_valid_i  (pix_valid_i),
  .pix_ready_o  (pix_ready_o),
  .pix_o        (pix_o),
  .pix_valid_o  (pix_valid_o),
  .out_ready_i  (out_ready_i),
  .com_o        (com_o),
  .com_valid_o  (com_valid_o),
  .dec_ready_i  (dec_ready)
);

`default_nettype wire

// ==== tb_color_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_color_tracker import video_pkg::*, track_pkg::*; ();

  localparam int HRES       = 16;
  localparam int VRES       = 8;
  localparam int NFRAMES    = 16;
  localparam int BEAT_WAIT  = 200; // cycles a beat may wait for pix_ready_o
  localparam int DRAIN_WAIT = 600; // cycles for a frame to leave the pipeline
  localparam int QUIET_WAIT = 40;  // window in which an empty frame must stay silent

  logic       clk_pixel;
  logic       recent_reset;
  pix_in_t    pix_i;
  logic       pix_valid_i;
  logic       pix_ready_o;
  track_cfg_t cfg_i;
  pix_out_t   pix_o;
  logic       pix_valid_o;
  logic       out_ready_i;
  com_t       com_o;
  logic       com_valid_o;

  pix_out_t exp_q[$]; // model output beats, oldest first
  com_t     com_q[$]; // model centers of mass not yet reported
  pix_out_t exp_pix;
  com_t     exp_com;
  coord_t   held_x, held_y; // model copy of the crosshair position
  int       tb_errors;
  logic     stall_en;
  string    test_name;

  color_tracker_top #(.HRES(HRES), .VRES(VRES)) dut0 (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .pix_i        (pix_i),
    .pix_valid_i  (pix_valid_i),
    .pix_ready_o  (pix_ready_o),
    .cfg_i        (cfg_i),
    .pix_o        (pix_o),
    .pix_valid_o  (pix_valid_o),
    .out_ready_i  (out_ready_i),
    .com_o        (com_o),
    .com_valid_o  (com_valid_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #5 clk_pixel = ~clk_pixel;
  end

  // 565 fields scaled up by a shift, low bits stay zero
  function automatic rgb888_t widen(input rgb565_t p);
    rgb888_t c;
    c.red   = chan_t'(p[15:11]) << 3;
    c.green = chan_t'(p[10:5]) << 2;
    c.blue  = chan_t'(p[4:0]) << 3;
    return c;
  endfunction

  function automatic chan_t pick(input rgb888_t c, input chan_sel_e sel);
    if (sel == SEL_RED) return c.red;
    if (sel == SEL_GREEN) return c.green;
    return c.blue; // code 3 counts as blue
  endfunction

  function automatic logic in_range(input chan_t ch, input track_cfg_t cfg);
    return (ch >= cfg.lower) && (ch <= cfg.upper);
  endfunction

  // overwrite the tracked field so the channel lands on v
  function automatic rgb565_t force_chan(input rgb565_t p, input chan_sel_e sel, input chan_t v);
    rgb565_t q;
    q = p;
    if (sel == SEL_RED) q[15:11] = v[7:3];
    else if (sel == SEL_GREEN) q[10:5] = v[7:2];
    else q[4:0] = v[7:3];
    return q;
  endfunction

  function automatic pix_out_t expect_pixel(input pix_in_t p, input track_cfg_t cfg);
    pix_out_t o;
    rgb888_t  c;
    chan_t    ch;
    c        = widen(p.rgb565);
    ch       = pick(c, cfg.chan_sel);
    o.hcount = p.hcount;
    o.vcount = p.vcount;
    case (cfg.disp_mode)
      DISP_CHANNEL:   o.rgb888 = {ch, ch, ch};
      DISP_MASK:      o.rgb888 = in_range(ch, cfg) ? 24'hffffff : 24'h000000;
      DISP_CROSSHAIR: o.rgb888 = (p.hcount == held_x || p.vcount == held_y) ? 24'hffffff : c;
      default:        o.rgb888 = c;
    endcase
    return o;
  endfunction

  task automatic next_cycle();
    @(negedge clk_pixel);
    out_ready_i = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1; // about 1 in 4 stalls
  endtask

  task automatic send_pixel(input pix_in_t p);
    int   n;
    logic fired;
    if ($urandom_range(0, 3) == 0) begin
      next_cycle();
      pix_valid_i = 1'b0; // idle gap
    end
    n     = 0;
    fired = 1'b0;
    while (!fired && n < BEAT_WAIT) begin
      next_cycle();
      pix_valid_i = 1'b1;
      pix_i       = p; // same payload until it is taken
      #1;
      fired = pix_ready_o;
      n++;
    end
    if (!fired) begin
      tb_errors++;
      $display("%s: pix_ready_o stayed low, beat %0d,%0d never accepted",
               test_name, p.hcount, p.vcount);
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || com_q.size() != 0) && n < DRAIN_WAIT) begin
      next_cycle();
      pix_valid_i = 1'b0;
      n++;
    end
    if (exp_q.size() != 0 || com_q.size() != 0) begin
      tb_errors++;
      $display("%s: timed out, %0d beats and %0d centers of mass never came out",
               test_name, exp_q.size(), com_q.size());
    end
  endtask

  task automatic run_frame(input int k);
    pix_in_t p;
    int      lo, hi, t;
    int      sum_x, sum_y, area;
    com_t    c;
    lo = $urandom_range(0, 31);
    hi = $urandom_range(0, 31);
    if (lo > hi) begin
      t  = lo;
      lo = hi;
      hi = t;
    end
    cfg_i.chan_sel  = chan_sel_e'(2'(k / 4)); // every select code meets every mode
    cfg_i.disp_mode = disp_mode_e'(2'((k + 3) % 4)); // frame 0 draws the crosshair
    cfg_i.lower     = (k == 3) ? 8'hff : chan_t'(lo * 8); // frame 3 masks nothing
    cfg_i.upper     = (k == 3) ? 8'hff : chan_t'(hi * 8);
    stall_en        = (k % 2 == 1); // never on crosshair frames
    test_name       = $sformatf("frame%0d", k);
    sum_x = 0;
    sum_y = 0;
    area  = 0;
    for (int v = 0; v < VRES; v++) begin
      for (int h = 0; h < HRES; h++) begin
        p.hcount = coord_t'(h);
        p.vcount = coord_t'(v);
        p.rgb565 = rgb565_t'($urandom);
        if (h == 3 && v == 2) p.rgb565 = force_chan(p.rgb565, cfg_i.chan_sel, cfg_i.lower);
        if (h == 9 && v == 5) p.rgb565 = force_chan(p.rgb565, cfg_i.chan_sel, cfg_i.upper);
        send_pixel(p);
        exp_q.push_back(expect_pixel(p, cfg_i));
        if (in_range(pick(widen(p.rgb565), cfg_i.chan_sel), cfg_i)) begin
          sum_x += h;
          sum_y += v;
          area++;
        end
      end
    end
    if (area != 0) begin
      c.x    = coord_t'(sum_x / area); // integer division truncates
      c.y    = coord_t'(sum_y / area);
      c.area = area_t'(area);
      com_q.push_back(c);
      held_x = c.x;
      held_y = c.y;
    end
    drain();
    if (area == 0) begin
      for (int i = 0; i < QUIET_WAIT; i++) next_cycle(); // a pulse here is flagged below
    end
  endtask

  // outputs sampled mid cycle, a transfer happens at the next rising edge
  always @(negedge clk_pixel) begin
    #2;
    if (!recent_reset && pix_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        tb_errors++;
        $display("%s: pix_o delivered a beat that was never sent", test_name);
      end else begin
        exp_pix = exp_q.pop_front();
        assert (pix_o === exp_pix) else begin
          tb_errors++;
          $display("FAILED %s pixel: expected %h actual %h", test_name, exp_pix, pix_o);
        end
      end
    end
    if (!recent_reset && com_valid_o) begin
      if (com_q.size() == 0) begin
        tb_errors++;
        $display("%s: com_valid_o pulsed with no nonzero frame pending", test_name);
      end else begin
        exp_com = com_q.pop_front();
        assert (com_o === exp_com) else begin
          tb_errors++;
          $display("FAILED %s center of mass: expected %0d,%0d,%0d actual %0d,%0d,%0d",
                   test_name, exp_com.x, exp_com.y, exp_com.area, com_o.x, com_o.y, com_o.area);
        end
      end
    end
  end

  initial begin
    void'($urandom(67922));
    recent_reset = 1'b1;
    pix_i        = '0;
    pix_valid_i  = 1'b0;
    out_ready_i  = 1'b0;
    cfg_i        = '0;
    stall_en     = 1'b0;
    held_x       = '0; // crosshair starts at row 0 and column 0
    held_y       = '0;
    tb_errors    = 0;
    test_name    = "reset";
    repeat (10) @(posedge clk_pixel);
    @(negedge clk_pixel);
    recent_reset = 1'b0;
    out_ready_i  = 1'b1;
    for (int k = 0; k < NFRAMES; k++) run_frame(k);
    $display("done: %0d model errors, %0d assertion failures",
             tb_errors, dut0.props0.assert_fails);
    if (tb_errors == 0 && dut0.props0.assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
video_pkg.sv
track_pkg.sv
pixel_decode.sv
blob_centroid.sv
overlay_result.sv
color_tracker_top.sv
tb_color_tracker_properties.sv
tb_color_tracker.sv

// ==== Bender.yml ====
package:
  name: color_tracker

sources:
  - video_pkg.sv
  - track_pkg.sv
  - pixel_decode.sv
  - blob_centroid.sv
  - overlay_result.sv
  - color_tracker_top.sv
  - target: test
    files:
      - tb_color_tracker_properties.sv
      - tb_color_tracker.sv
